// ==== telemetry_trace.txt ====
// Columns: cycle (16 bits) _ event (4 bits) _ value (20 bits), cycles counted after reset
// Events: 1 new status, 2 enable, 3 button press, 4 UART byte in, F end of trace
000A_2_00001
001E_1_00001
002D_1_00ABC
003C_1_12345
003D_1_12346
005A_1_FFFFF
00C8_3_00000
0BB8_1_0AAAA
1F40_4_00062
206C_1_00777
209E_1_00778
2134_4_00061
2EE0_2_00000
2EEA_1_0BEEF
2EF4_2_00001
2EFE_1_0CAFE
2F08_1_00010
2F12_1_00020
2F1C_1_00030
2F26_1_00040
2F30_1_00050
2F3A_1_00060
2F44_1_00070
2F4E_1_00080
2F58_1_00090
2F62_1_000A0
30D4_3_00000
61A8_3_00000
639C_F_00000

// ==== telemetry_core.f ====
+incdir+.
tlm_pkg.sv
serial_pkg.sv
change_logger.sv
sample_fifo.sv
hex_encoder.sv
uart_link.sv
dump_ctrl.sv
telemetry_core.sv
telemetry_props.sv
telemetry_monitor.sv
tb_telemetry_core.sv

// ==== tb_telemetry_core.sv ====
`include "telemetry_defines.svh"

module tb_telemetry_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PRE = `TLM_UART_PRESCALE;

  logic                      clock = 1'b0;
  logic                      reset_i;
  logic                      enable_i;
  logic [`TLM_SIG_WIDTH-1:0] status_i;
  logic                      send_n_i;
  logic                      uart_rx_i;
  logic                      uart_tx_o;
  logic                      dumping_o;
  logic                      overflow_o;
  logic [39:0]               trace_mem [64];
  int  cycle = 0;
  int  idx = 0;
  longint limit_ns = 0;

  always #5 clock = ~clock;

  telemetry_core dut_i (.*);

  telemetry_monitor mon_i (
    .clock(clock), .reset_i(reset_i), .enable_i(enable_i), .status_i(status_i),
    .uart_tx_i(uart_tx_o), .dumping_i(dumping_o), .overflow_i(overflow_o)
  );

  task automatic step_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      cycle++;
    end
  endtask

  // 8N1 frame on the receive line, LSB first
  task automatic send_uart_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx_i <= frame[i];
      step_cycles(PRE);
    end
  endtask

  initial begin : stimulus
    int n_status;
    reset_i = 1'b1;
    enable_i = 1'b0;
    status_i = '0;
    send_n_i = 1'b1;
    uart_rx_i = 1'b1;
    n_status = 0;
    $readmemh("telemetry_trace.txt", trace_mem);
    while (trace_mem[idx][23:20] !== 4'hf) begin
      if (trace_mem[idx][23:20] == 4'h1) n_status++;
      idx++;
    end
    // Last event plus one full line per possible record, with margin
    limit_ns = 10 * (longint'(trace_mem[idx][39:24]) + n_status * 9 * 10 * PRE + 4000);
    idx = 0;
    repeat (3) @(posedge clock);
    reset_i <= 1'b0;
    while (trace_mem[idx][23:20] !== 4'hf) begin
      while (cycle < trace_mem[idx][39:24]) step_cycles(1);
      case (trace_mem[idx][23:20])
        4'h1: status_i <= trace_mem[idx][19:0];
        4'h2: enable_i <= trace_mem[idx][0];
        4'h3: begin
          send_n_i <= 1'b0;
          step_cycles(4);
          send_n_i <= 1'b1;
        end
        4'h4: send_uart_byte(trace_mem[idx][7:0]);
        default: ;
      endcase
      idx++;
    end
    while (cycle < trace_mem[idx][39:24]) step_cycles(1);
    while (dumping_o || mon_i.pending() != 0) step_cycles(1);
    step_cycles(50);
    mon_i.final_check();
    $display("Errors: %0d during run, %0d at end of run, %0d assertion failures",
             mon_i.error_count, mon_i.end_errors, dut_i.u_dump_ctrl.props_i.fail_count);
    if (mon_i.error_count == 0 && mon_i.end_errors == 0 &&
        dut_i.u_dump_ctrl.props_i.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit_ns > 0);
    #(limit_ns);
    $display("The run timed out before the trace and its dumps completed");
    $display("Something failed");
    $finish;
  end

endmodule

// ==== telemetry_monitor.sv ====
`include "telemetry_defines.svh"

module telemetry_monitor (
  input logic                      clock,
  input logic                      reset_i,
  input logic                      enable_i,
  input logic [`TLM_SIG_WIDTH-1:0] status_i,
  input logic                      uart_tx_i,
  input logic                      dumping_i,
  input logic                      overflow_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PRE = `TLM_UART_PRESCALE;
  localparam string HEX = "0123456789ABCDEF";

  logic [39:0]                trace_mem [64];
  logic [7:0]                 exp_q [$];  // Characters still to appear on the line
  logic [`TLM_DELTA_WIDTH-1:0] delta;
  logic [`TLM_SIG_WIDTH-1:0]  prev;
  logic                       ovf;
  logic                       dump_seen;
  int occ;
  int error_count = 0;
  int end_errors = 0;
  int dump_count = 0;
  int expected_dumps = 0;

  initial begin
    $readmemh("telemetry_trace.txt", trace_mem);
    for (int i = 0; i < 64 && trace_mem[i][23:20] !== 4'hf; i++) begin
      if (trace_mem[i][23:20] == 4'h3) expected_dumps++;
      if (trace_mem[i][23:20] == 4'h4 && trace_mem[i][7:0] == 8'h61) expected_dumps++;
    end
  end

  task automatic push_record(input logic [31:0] rec);
    for (int n = 7; n >= 0; n--) exp_q.push_back(HEX[rec[4*n +: 4]]);
    exp_q.push_back(8'h0a);  // Line feed closes each record
  endtask

  // Reference model of capture, sampled before the edge updates anything
  always @(posedge clock) begin
    if (reset_i) begin
      delta = '0;
      prev = '0;
      occ = 0;
      ovf = 1'b0;
      dump_seen = 1'b0;
    end else begin
      if (dumping_i) begin
        if (!dump_seen) dump_count++;
        if (overflow_i !== 1'b0) begin
          $display("ERROR at %0t: overflow still set during dump", $time);
          error_count++;
        end
        occ = 0;  // Every stored record leaves during the dump
        ovf = 1'b0;
      end else if (overflow_i !== ovf) begin
        $display("ERROR at %0t: overflow is %b, expected %b", $time, overflow_i, ovf);
        error_count++;
      end
      dump_seen = dumping_i;
      if (enable_i && !dumping_i && status_i != prev) begin
        if (occ < `TLM_REC_DEPTH) begin
          push_record({delta, status_i});
          occ++;
          delta = '0;
        end else begin
          ovf = 1'b1;
          if (delta != '1) delta++;
        end
      end else if (enable_i && !dumping_i && delta != '1) begin
        delta++;
      end
      prev = status_i;
    end
  end

  // UART decoder, samples each bit in its middle
  initial begin : uart_decode
    logic [7:0] ch;
    forever begin
      @(posedge clock);
      if (!reset_i && uart_tx_i === 1'b0) begin
        repeat (PRE / 2 - 1) @(posedge clock);
        for (int b = 0; b < 8; b++) begin
          repeat (PRE) @(posedge clock);
          ch[b] = uart_tx_i;
        end
        repeat (PRE) @(posedge clock);
        if (uart_tx_i !== 1'b1) begin
          $display("ERROR at %0t: missing stop bit", $time);
          error_count++;
        end
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t: unexpected character %h", $time, ch);
          error_count++;
        end else if (exp_q[0] !== ch) begin
          $display("ERROR at %0t: got character %h, expected %h", $time, ch, exp_q[0]);
          error_count++;
          void'(exp_q.pop_front());
        end else begin
          void'(exp_q.pop_front());
        end
      end
    end
  end

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic final_check();
    if (exp_q.size() != 0) begin
      $display("ERROR at %0t: %0d characters never sent", $time, exp_q.size());
      end_errors++;
    end
    if (dump_count != expected_dumps) begin
      $display("ERROR at %0t: %0d dumps seen, expected %0d", $time, dump_count,
               expected_dumps);
      end_errors++;
    end
  endtask

endmodule

// ==== telemetry_props.sv ====
module telemetry_props (
  input logic clock,
  input logic reset_i,
  input logic start_req_i,
  input logic dumping_i,
  input logic rec_empty_i,
  input logic tx_busy_i,
  input logic chr_empty_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // Read by the testbench top

  // A dump starts two cycles after its request
  rise_needs_request: assert property (@(posedge clock) disable iff (reset_i)
    $rose(dumping_i) |-> $past(start_req_i, 2))
    else begin
      fail_count++;
      $error("dumping rose without a start request");
    end

  // Capture is off in a dump, so an emptied record FIFO stays empty until it ends
  no_capture_in_dump: assert property (@(posedge clock) disable iff (reset_i)
    (dumping_i && rec_empty_i) |=> (!dumping_i || rec_empty_i))
    else begin
      fail_count++;
      $error("record captured during a dump");
    end

  // Outside a dump the transmitter stays idle, so the line stays high
  tx_idle_outside_dump: assert property (@(posedge clock) disable iff (reset_i)
    !dumping_i |-> (!tx_busy_i && chr_empty_i))
    else begin
      fail_count++;
      $error("transmitter active outside a dump");
    end

endmodule

bind dump_ctrl telemetry_props props_i (
  .clock(clock), .reset_i(reset_i), .start_req_i(start_req),
  .dumping_i(dumping_o), .rec_empty_i(rec_empty_i),
  .tx_busy_i(tx_busy_i), .chr_empty_i(chr_empty_i)
);

// ==== telemetry_core.sv ====
`include "telemetry_defines.svh"

module telemetry_core (
  input  logic                 clock,
  input  logic                 reset_i,
  input  logic                 enable_i,
  input  tlm_pkg::tlm_signal_t status_i,
  input  logic                 send_n_i,
  input  logic                 uart_rx_i,
  output logic                 uart_tx_o,
  output logic                 dumping_o,
  output logic                 overflow_o
);

  // Record stream, logger into FIFO and FIFO into encoder
  logic                 log_valid, log_ready, log_drop;
  tlm_pkg::tlm_record_t log_data;
  logic                 rec_valid, rec_ready, rec_empty;
  tlm_pkg::tlm_record_t rec_data;

  // Character stream, encoder into FIFO and FIFO into UART
  logic                     enc_valid, enc_ready, line_done;
  serial_pkg::serial_byte_t enc_data;
  logic                     chr_valid, chr_ready, chr_empty;
  serial_pkg::serial_byte_t chr_data;

  logic                     rx_valid, tx_busy;
  serial_pkg::serial_byte_t rx_data;
  logic                     capture_en, dump_en;

  change_logger u_change_logger (
    .clock(clock), .reset_i(reset_i),
    .capture_en_i(capture_en), .status_i(status_i),
    .rec_valid_o(log_valid), .rec_ready_i(log_ready),
    .rec_data_o(log_data), .rec_drop_o(log_drop)
  );

  sample_fifo #(
    .payload_t(tlm_pkg::tlm_record_t),
    .DEPTH(`TLM_REC_DEPTH)
  ) u_rec_fifo (
    .clock(clock), .reset_i(reset_i),
    .wr_valid_i(log_valid), .wr_ready_o(log_ready), .wr_data_i(log_data),
    .rd_valid_o(rec_valid), .rd_ready_i(rec_ready), .rd_data_o(rec_data),
    .empty_o(rec_empty)
  );

  hex_encoder u_hex_encoder (
    .clock(clock), .reset_i(reset_i), .dump_en_i(dump_en),
    .rec_valid_i(rec_valid), .rec_ready_o(rec_ready), .rec_data_i(rec_data),
    .chr_valid_o(enc_valid), .chr_ready_i(enc_ready), .chr_data_o(enc_data),
    .line_done_o(line_done)
  );

  sample_fifo #(
    .payload_t(serial_pkg::serial_byte_t),
    .DEPTH(`TLM_CHAR_DEPTH)
  ) u_chr_fifo (
    .clock(clock), .reset_i(reset_i),
    .wr_valid_i(enc_valid), .wr_ready_o(enc_ready), .wr_data_i(enc_data),
    .rd_valid_o(chr_valid), .rd_ready_i(chr_ready), .rd_data_o(chr_data),
    .empty_o(chr_empty)
  );

  uart_link u_uart_link (
    .clock(clock), .reset_i(reset_i),
    .tx_valid_i(chr_valid), .tx_ready_o(chr_ready), .tx_data_i(chr_data),
    .uart_tx_o(uart_tx_o), .uart_rx_i(uart_rx_i),
    .rx_valid_o(rx_valid), .rx_data_o(rx_data), .tx_busy_o(tx_busy)
  );

  dump_ctrl u_dump_ctrl (
    .clock(clock), .reset_i(reset_i), .enable_i(enable_i), .send_n_i(send_n_i),
    .rx_valid_i(rx_valid), .rx_data_i(rx_data),
    .rec_empty_i(rec_empty), .line_done_i(line_done),
    .chr_empty_i(chr_empty), .tx_busy_i(tx_busy), .rec_drop_i(log_drop),
    .capture_en_o(capture_en), .dump_en_o(dump_en),
    .dumping_o(dumping_o), .overflow_o(overflow_o)
  );

endmodule

// ==== dump_ctrl.sv ====
module dump_ctrl (
  input  logic                     clock,
  input  logic                     reset_i,
  input  logic                     enable_i,
  input  logic                     send_n_i,
  input  logic                     rx_valid_i,
  input  serial_pkg::serial_byte_t rx_data_i,
  input  logic                     rec_empty_i,
  input  logic                     line_done_i,
  input  logic                     chr_empty_i,
  input  logic                     tx_busy_i,
  input  logic                     rec_drop_i,
  output logic                     capture_en_o,
  output logic                     dump_en_o,
  output logic                     dumping_o,
  output logic                     overflow_o
);

  typedef enum logic [1:0] {
    IDLE,
    DUMP,   // Encoder draws records
    DRAIN   // Waiting for the last characters to leave
  } state_t;

  state_t     state_q;
  logic [2:0] send_sync_q;  // Two sync stages, then the previous value
  logic       btn_fall;
  logic       cmd_dump;
  logic       start_req;
  logic       req_q;
  logic       entry_q;      // First cycle in DUMP
  logic       overflow_q;

  assign btn_fall  = send_sync_q[2] && !send_sync_q[1];
  assign cmd_dump  = rx_valid_i && (rx_data_i == serial_pkg::CMD_DUMP);
  assign start_req = btn_fall || cmd_dump;

  assign capture_en_o = enable_i && (state_q == IDLE);
  assign dump_en_o    = (state_q == DUMP);
  assign dumping_o    = (state_q != IDLE);
  assign overflow_o   = overflow_q;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      send_sync_q <= '1;  // Button released
      state_q     <= IDLE;
      req_q       <= 1'b0;
      entry_q     <= 1'b0;
      overflow_q  <= 1'b0;
    end else begin
      send_sync_q <= {send_sync_q[1:0], send_n_i};
      req_q       <= start_req && (state_q == IDLE) && !req_q;
      entry_q     <= req_q;

      if (req_q) begin
        overflow_q <= 1'b0;
      end else if (rec_drop_i) begin
        overflow_q <= 1'b1;
      end

      case (state_q)
        IDLE:    if (req_q) state_q <= DUMP;
        // Only leave between lines, never mid-record
        DUMP:    if ((entry_q || line_done_i) && rec_empty_i) state_q <= DRAIN;
        DRAIN:   if (chr_empty_i && !tx_busy_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// ==== uart_link.sv ====
`include "telemetry_defines.svh"

module uart_link (
  input  logic                     clock,
  input  logic                     reset_i,
  input  logic                     tx_valid_i,
  output logic                     tx_ready_o,
  input  serial_pkg::serial_byte_t tx_data_i,
  output logic                     uart_tx_o,
  input  logic                     uart_rx_i,
  output logic                     rx_valid_o,
  output serial_pkg::serial_byte_t rx_data_o,
  output logic                     tx_busy_o
);

  localparam int            PRESCALE   = `TLM_UART_PRESCALE;
  localparam int            CW         = $clog2(PRESCALE);
  localparam logic [CW-1:0] BIT_LAST   = CW'(PRESCALE - 1);
  localparam logic [CW-1:0] BIT_HALF   = CW'(PRESCALE / 2 - 1);
  localparam logic [3:0]    FRAME_LAST = 4'd9;  // Stop bit index

  logic [9:0]    tx_shift_q;  // Stop, data, start, sent from bit 0
  logic [CW-1:0] tx_cnt_q;
  logic [3:0]    tx_bit_q;
  logic          tx_busy_q;
  logic          tx_tick;
  logic          tx_done;
  logic          tx_load;

  logic [1:0]               rx_sync_q;
  logic                     rx_s;
  logic [CW-1:0]            rx_cnt_q;
  logic [3:0]               rx_bit_q;
  logic                     rx_busy_q;
  logic                     rx_tick;
  logic                     rx_take;
  logic                     rx_valid_q;
  serial_pkg::serial_byte_t rx_shift_q;

  // Transmitter
  assign tx_tick    = (tx_cnt_q == '0);
  assign tx_done    = tx_busy_q && tx_tick && (tx_bit_q == FRAME_LAST);
  assign tx_ready_o = !tx_busy_q || tx_done;  // Next frame follows the stop bit directly
  assign tx_load    = tx_valid_i && tx_ready_o;
  assign uart_tx_o  = tx_shift_q[0];
  assign tx_busy_o  = tx_busy_q;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      tx_shift_q <= '1;  // Line idles high
      tx_cnt_q   <= '0;
      tx_bit_q   <= '0;
      tx_busy_q  <= 1'b0;
    end else if (tx_load) begin
      tx_shift_q <= {1'b1, tx_data_i, 1'b0};
      tx_cnt_q   <= BIT_LAST;
      tx_bit_q   <= '0;
      tx_busy_q  <= 1'b1;
    end else if (tx_busy_q) begin
      if (tx_tick) begin
        tx_cnt_q   <= BIT_LAST;
        tx_shift_q <= {1'b1, tx_shift_q[9:1]};
        tx_bit_q   <= tx_bit_q + 1'b1;
        if (tx_done) tx_busy_q <= 1'b0;
      end else begin
        tx_cnt_q <= tx_cnt_q - 1'b1;
      end
    end
  end

  // Receiver, same down-counter, started half a bit in
  assign rx_s       = rx_sync_q[1];
  assign rx_tick    = (rx_cnt_q == '0);
  assign rx_take    = rx_busy_q && rx_tick && (rx_bit_q != '0) && (rx_bit_q != FRAME_LAST);
  assign rx_valid_o = rx_valid_q;
  assign rx_data_o  = rx_shift_q;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      rx_sync_q  <= '1;
      rx_cnt_q   <= '0;
      rx_bit_q   <= '0;
      rx_busy_q  <= 1'b0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_sync_q  <= {rx_sync_q[0], uart_rx_i};
      rx_valid_q <= 1'b0;
      if (!rx_busy_q) begin
        if (!rx_s) begin  // Falling edge of a start bit
          rx_busy_q <= 1'b1;
          rx_cnt_q  <= BIT_HALF;
          rx_bit_q  <= '0;
        end
      end else if (!rx_tick) begin
        rx_cnt_q <= rx_cnt_q - 1'b1;
      end else begin
        rx_cnt_q <= BIT_LAST;
        rx_bit_q <= rx_bit_q + 1'b1;
        if ((rx_bit_q == '0) && rx_s) begin
          rx_busy_q <= 1'b0;  // Glitch, not a real start bit
        end else if (rx_bit_q == FRAME_LAST) begin
          rx_busy_q  <= 1'b0;
          rx_valid_q <= rx_s;  // Framing error drops the byte
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rx_take) rx_shift_q <= {rx_s, rx_shift_q[7:1]};  // LSB arrives first
  end

endmodule

// ==== hex_encoder.sv ====
module hex_encoder (
  input  logic                     clock,
  input  logic                     reset_i,
  input  logic                     dump_en_i,
  input  logic                     rec_valid_i,
  output logic                     rec_ready_o,
  input  tlm_pkg::tlm_record_t     rec_data_i,
  output logic                     chr_valid_o,
  input  logic                     chr_ready_i,
  output serial_pkg::serial_byte_t chr_data_o,
  output logic                     line_done_o
);

  localparam int RW = $bits(tlm_pkg::tlm_record_t);

  tlm_pkg::tlm_record_t rec_q;
  logic [RW-1:0]        rec_bits;
  logic                 busy_q;  // A line is being printed
  logic [3:0]           idx_q;   // 0..7 hex digits, 8 is the line feed
  logic                 line_done_q;
  logic [2:0]           nib_pos;
  logic [3:0]           nibble;
  logic                 take_rec;
  logic                 chr_fire;
  logic                 last_chr;

  assign rec_ready_o = dump_en_i && !busy_q;
  assign take_rec    = rec_valid_i && rec_ready_o;
  assign chr_valid_o = busy_q;
  assign chr_fire    = chr_valid_o && chr_ready_i;
  assign last_chr    = (idx_q == 4'd8);
  assign line_done_o = line_done_q;

  // Most significant nibble goes out first
  assign rec_bits = rec_q;
  assign nib_pos  = 3'd7 - idx_q[2:0];
  assign nibble   = rec_bits[{nib_pos, 2'b00} +: 4];

  always_comb begin
    if (last_chr) begin
      chr_data_o = serial_pkg::CHAR_LF;
    end else if (nibble < 4'd10) begin
      chr_data_o = serial_pkg::CHAR_ZERO + 8'(nibble);
    end else begin
      chr_data_o = serial_pkg::CHAR_UPPER_A + 8'(nibble) - 8'd10;
    end
  end

  always_ff @(posedge clock) begin
    if (take_rec) rec_q <= rec_data_i;
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      busy_q      <= 1'b0;
      idx_q       <= '0;
      line_done_q <= 1'b0;
    end else begin
      line_done_q <= chr_fire && last_chr;  // One cycle after the LF leaves
      if (take_rec) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end else if (chr_fire) begin
        if (last_chr) busy_q <= 1'b0;
        idx_q <= idx_q + 1'b1;
      end
    end
  end

endmodule

// ==== sample_fifo.sv ====
module sample_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 8
) (
  input  logic     clock,
  input  logic     reset_i,
  input  logic     wr_valid_i,
  output logic     wr_ready_o,
  input  payload_t wr_data_i,
  output logic     rd_valid_o,
  input  logic     rd_ready_i,
  output payload_t rd_data_o,
  output logic     empty_o
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem_q [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;  // Entries currently held
  logic          do_wr;
  logic          do_rd;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_ready_o = (count_q != CW'(DEPTH));
  assign rd_valid_o = (count_q != '0);
  assign empty_o    = (count_q == '0);
  assign rd_data_o  = mem_q[rd_ptr_q];  // Head of queue, read without latency

  assign do_wr = wr_valid_i && wr_ready_o;
  assign do_rd = rd_valid_o && rd_ready_i;

  always_ff @(posedge clock) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_rd) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

endmodule

// ==== change_logger.sv ====
module change_logger (
  input  logic                  clock,
  input  logic                  reset_i,
  input  logic                  capture_en_i,
  input  tlm_pkg::tlm_signal_t  status_i,
  output logic                  rec_valid_o,
  input  logic                  rec_ready_i,
  output tlm_pkg::tlm_record_t  rec_data_o,
  output logic                  rec_drop_o
);

  tlm_pkg::tlm_signal_t prev_q;  // Status seen on the previous cycle
  tlm_pkg::tlm_delta_t  delta_q;
  logic                 changed;
  logic                 written;

  // A record is offered in the cycle after the status moved
  assign changed     = capture_en_i && (status_i != prev_q);
  assign rec_valid_o = changed;
  assign rec_data_o  = '{delta: delta_q, status: status_i};

  // No stalling here, a full FIFO loses the record
  assign rec_drop_o = changed && !rec_ready_i;
  assign written    = changed && rec_ready_i;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      prev_q  <= '0;
      delta_q <= '0;
    end else begin
      prev_q <= status_i;  // Tracks even while disabled

      if (written) begin
        delta_q <= '0;
      end else if (capture_en_i && (delta_q != '1)) begin
        delta_q <= delta_q + 1'b1;  // Sticks at all ones
      end
    end
  end

endmodule

// ==== serial_pkg.sv ====
package serial_pkg;

  // One character on the UART
  typedef logic [7:0] serial_byte_t;

  // Command byte that requests a dump
  localparam serial_byte_t CMD_DUMP = "a";

  // Characters used when printing records
  localparam serial_byte_t CHAR_LF      = 8'h0a;  // End of each record line
  localparam serial_byte_t CHAR_ZERO    = "0";
  localparam serial_byte_t CHAR_UPPER_A = "A";    // Hex digits above nine

endpackage

// ==== tlm_pkg.sv ====
`include "telemetry_defines.svh"

package tlm_pkg;

  // Status vector as seen at the capture input
  typedef logic [`TLM_SIG_WIDTH-1:0] tlm_signal_t;

  // Cycles since the previous record, saturating
  typedef logic [`TLM_DELTA_WIDTH-1:0] tlm_delta_t;

  // One captured change, delta in the upper bits
  typedef struct packed {
    tlm_delta_t  delta;
    tlm_signal_t status;
  } tlm_record_t;

endpackage

// ==== telemetry_defines.svh ====
`ifndef TELEMETRY_DEFINES_SVH
`define TELEMETRY_DEFINES_SVH

// Status vector and timestamp field, 32-bit record in total
`define TLM_SIG_WIDTH 20
`define TLM_DELTA_WIDTH 12

// Buffering
`define TLM_REC_DEPTH 8    // Records held between dumps
`define TLM_CHAR_DEPTH 16  // ASCII characters waiting for the UART

// Clock cycles per UART bit
`define TLM_UART_PRESCALE 16

`endif
